// ==== hw/fp_noncomp_macros.svh ====
`ifndef FP_NONCOMP_MACROS_SVH
`define FP_NONCOMP_MACROS_SVH

// ------------------------------------------------------------
// Binary32 field widths
// ------------------------------------------------------------

// Biased exponent field
`define FP_EXP_BITS 8

// Fraction field without the hidden bit
`define FP_MAN_BITS 23

// Full word, sign plus exponent plus fraction
`define FP_WIDTH 32

// ------------------------------------------------------------
// Side-band and constants
// ------------------------------------------------------------

// Tag carried alongside every item
`define FP_TAG_WIDTH 8

// Canonical quiet NaN, positive sign and only the quiet bit set
`define FP_CANON_NAN 32'h7FC0_0000

`endif

// ==== hw/fp_noncomp_pkg.sv ====
`include "fp_noncomp_macros.svh"

package fp_noncomp_pkg;

  // ------------------------------------------------------------
  // Operand format and class info
  // ------------------------------------------------------------

  // Binary32 fields, MSB first
  typedef struct packed {
    logic                    sign;
    logic [`FP_EXP_BITS-1:0] exponent;
    logic [`FP_MAN_BITS-1:0] mantissa;
  } fp_t;

  // Decoded class of one operand
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
    logic is_quiet;
  } fp_info_t;

  // ------------------------------------------------------------
  // Operation encodings
  // ------------------------------------------------------------

  // Main operation group
  typedef enum logic [1:0] {SGNJ, MINMAX, CMP, CLASSIFY} op_e;

  // Rounding-mode field, reused here as the sub-operation select
  typedef enum logic [2:0] {RNE = 3'b000, RTZ = 3'b001, RDN = 3'b010, RUP = 3'b011} rnd_e;

  // IEEE exception flags
  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // One-hot class mask, bit order as in the RISC-V FCLASS result
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // ------------------------------------------------------------
  // Request and response
  // ------------------------------------------------------------
  typedef struct packed {
    fp_t                      operand_a;
    fp_t                      operand_b;
    op_e                      op;
    rnd_e                     rnd;
    logic                     op_mod;
    logic [`FP_TAG_WIDTH-1:0] tag;
  } noncomp_req_t;

  typedef struct packed {
    logic [`FP_WIDTH-1:0]     result;
    status_t                  status;
    logic                     extension_bit;
    classmask_e               class_mask;
    logic                     is_class;
    logic [`FP_TAG_WIDTH-1:0] tag;
  } noncomp_rsp_t;

endpackage

// ==== hw/fp_classifier.sv ====
`timescale 1ns/10ps
`include "fp_noncomp_macros.svh"

module fp_classifier (
  input  fp_noncomp_pkg::fp_t      operand_i,
  output fp_noncomp_pkg::fp_info_t info_o
);
  import fp_noncomp_pkg::*;

  // Field summaries
  logic     exp_ones;
  logic     exp_zero;
  logic     man_zero;
  logic     quiet_bit;
  fp_info_t info;

  // Exponent all ones marks inf and NaN, all zeros marks zero and subnormal
  assign exp_ones  = &operand_i.exponent;
  assign exp_zero  = ~|operand_i.exponent;
  assign man_zero  = ~|operand_i.mantissa;
  // Top fraction bit separates quiet from signalling NaNs
  assign quiet_bit = operand_i.mantissa[`FP_MAN_BITS-1];

  // ------------------------------------------------------------
  // Class flags
  // ------------------------------------------------------------
  always_comb begin
    info              = '0;
    info.is_normal    = ~exp_ones & ~exp_zero;
    info.is_subnormal = exp_zero & ~man_zero;
    info.is_zero      = exp_zero & man_zero;
    info.is_inf       = exp_ones & man_zero;
    info.is_nan       = exp_ones & ~man_zero;
    // sNaN has a clear quiet bit but a nonzero fraction
    info.is_signalling = info.is_nan & ~quiet_bit;
    info.is_quiet      = info.is_nan & quiet_bit;
  end

  assign info_o = info;

endmodule

// ==== hw/fp_noncomp_ops.sv ====
`timescale 1ns/10ps
`include "fp_noncomp_macros.svh"

module fp_noncomp_ops (
  input  fp_noncomp_pkg::noncomp_req_t req_i,
  output fp_noncomp_pkg::noncomp_rsp_t rsp_o
);
  import fp_noncomp_pkg::*;

  fp_t        operand_a;
  fp_t        operand_b;
  fp_info_t   info_a;
  fp_info_t   info_b;
  logic       any_nan;
  logic       signalling_nan;
  logic       operands_equal;
  logic       a_smaller;
  fp_t        sgnj_result;
  logic       sgnj_ext;
  fp_t        minmax_result;
  status_t    minmax_status;
  logic       cmp_bit;
  status_t    cmp_status;
  classmask_e class_mask;
  logic [`FP_WIDTH-1:0] result_d;
  status_t    status_d;
  logic       ext_d;

  assign operand_a = req_i.operand_a;
  assign operand_b = req_i.operand_b;

  // Both operands are decoded in parallel
  fp_classifier u_class_a (.operand_i(operand_a), .info_o(info_a));
  fp_classifier u_class_b (.operand_i(operand_b), .info_o(info_b));

  assign any_nan        = info_a.is_nan | info_b.is_nan;
  assign signalling_nan = info_a.is_signalling | info_b.is_signalling;

  // +0 and -0 compare equal
  assign operands_equal = (operand_a == operand_b) || (info_a.is_zero && info_b.is_zero);
  // Sign-magnitude order via unsigned compare, flipped once a sign is set
  assign a_smaller = (operand_a < operand_b) ^ (operand_a.sign | operand_b.sign);

  // ------------------------------------------------------------
  // Sign injection
  // ------------------------------------------------------------
  always_comb begin
    sgnj_result = operand_a;
    unique case (req_i.rnd)
      RNE:     sgnj_result.sign = operand_b.sign;
      RTZ:     sgnj_result.sign = ~operand_b.sign;
      RDN:     sgnj_result.sign = operand_a.sign ^ operand_b.sign;
      RUP:     sgnj_result = operand_a;
      default: sgnj_result = '0;
    endcase
  end

  // op_mod asks for integer sign extension of the result
  assign sgnj_ext = req_i.op_mod ? sgnj_result.sign : 1'b1;

  // ------------------------------------------------------------
  // Minimum and maximum
  // ------------------------------------------------------------
  always_comb begin
    minmax_status = '0;
    // Quiet comparison, only sNaN is invalid
    minmax_status.NV = signalling_nan;
    if (info_a.is_nan && info_b.is_nan) begin
      minmax_result = fp_t'(`FP_CANON_NAN);
    end else if (info_a.is_nan) begin
      minmax_result = operand_b;
    end else if (info_b.is_nan) begin
      minmax_result = operand_a;
    end else begin
      unique case (req_i.rnd)
        RNE:     minmax_result = a_smaller ? operand_a : operand_b;
        RTZ:     minmax_result = a_smaller ? operand_b : operand_a;
        default: minmax_result = '0;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Comparisons
  // ------------------------------------------------------------
  always_comb begin
    cmp_bit    = 1'b0;
    cmp_status = '0;
    if (signalling_nan) begin
      // sNaN is invalid everywhere, only "not equal" comes out true
      cmp_status.NV = 1'b1;
      cmp_bit       = (req_i.rnd == RDN) && req_i.op_mod;
    end else begin
      unique case (req_i.rnd)
        RNE: begin
          if (any_nan) cmp_status.NV = 1'b1;
          else cmp_bit = (a_smaller | operands_equal) ^ req_i.op_mod;
        end
        RTZ: begin
          if (any_nan) cmp_status.NV = 1'b1;
          else cmp_bit = (a_smaller & ~operands_equal) ^ req_i.op_mod;
        end
        // qNaN is never equal, so EQ stays quiet
        RDN:     cmp_bit = any_nan ? req_i.op_mod : (operands_equal ^ req_i.op_mod);
        default: cmp_bit = 1'b0;
      endcase
    end
  end

  // ------------------------------------------------------------
  // Classification and result select
  // ------------------------------------------------------------
  always_comb begin
    if (info_a.is_normal) class_mask = operand_a.sign ? NEGNORM : POSNORM;
    else if (info_a.is_subnormal) class_mask = operand_a.sign ? NEGSUBNORM : POSSUBNORM;
    else if (info_a.is_zero) class_mask = operand_a.sign ? NEGZERO : POSZERO;
    else if (info_a.is_inf) class_mask = operand_a.sign ? NEGINF : POSINF;
    else class_mask = info_a.is_signalling ? SNAN : QNAN;
  end

  always_comb begin
    unique case (req_i.op)
      SGNJ: begin
        result_d = sgnj_result;
        status_d = '0;
        ext_d    = sgnj_ext;
      end
      MINMAX: begin
        result_d = minmax_result;
        status_d = minmax_status;
        ext_d    = 1'b1;
      end
      // Boolean lands in bit 0 of an integer register
      CMP: begin
        result_d = {{(`FP_WIDTH-1){1'b0}}, cmp_bit};
        status_d = cmp_status;
        ext_d    = 1'b0;
      end
      CLASSIFY: begin
        result_d = '0;
        status_d = '0;
        ext_d    = 1'b0;
      end
    endcase
  end

  assign rsp_o.result        = result_d;
  assign rsp_o.status        = status_d;
  assign rsp_o.extension_bit = ext_d;
  assign rsp_o.class_mask    = class_mask;
  assign rsp_o.is_class      = (req_i.op == CLASSIFY);
  assign rsp_o.tag           = req_i.tag;

endmodule

// ==== hw/fp_pipe_stage.sv ====
`timescale 1ns/10ps

module fp_pipe_stage #(
  parameter type payload_t = fp_noncomp_pkg::noncomp_req_t
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // ------------------------------------------------------------
  // Handshake
  // ------------------------------------------------------------

  // Accept when empty or when the held item leaves this cycle
  assign ready_o = ready_i | ~valid_q;

  // Valid flag, flush drops whatever is held
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload loads only on an actual transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== hw/fp_noncomp_top.sv ====
`timescale 1ns/10ps

module fp_noncomp_top (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         flush_i,
  // Request side
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  fp_noncomp_pkg::noncomp_req_t in_req_i,
  // Response side
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output fp_noncomp_pkg::noncomp_rsp_t out_rsp_o,
  // Any item in flight
  output logic                         busy_o
);
  import fp_noncomp_pkg::*;

  // Between input stage and output stage
  logic         mid_valid;
  logic         mid_ready;
  noncomp_req_t mid_req;
  noncomp_rsp_t mid_rsp;

  // ------------------------------------------------------------
  // Input register
  // ------------------------------------------------------------
  fp_pipe_stage #(
    .payload_t (noncomp_req_t)
  ) u_in_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (in_req_i),
    .valid_o (mid_valid),
    .ready_i (mid_ready),
    .data_o  (mid_req)
  );

  // Combinational operation core
  fp_noncomp_ops u_ops (
    .req_i (mid_req),
    .rsp_o (mid_rsp)
  );

  // ------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------
  fp_pipe_stage #(
    .payload_t (noncomp_rsp_t)
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (mid_valid),
    .ready_o (mid_ready),
    .data_i  (mid_rsp),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_rsp_o)
  );

  // Busy while either register holds an item
  assign busy_o = mid_valid | out_valid_o;

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 10 ns period, starts low
  initial begin
    clk_o = 1'b0;
    forever begin
      #5 clk_o = ~clk_o;
    end
  end

  // Reset held for four rising edges, released on an edge
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== verif/fp_noncomp_tb.sv ====
`timescale 1ns/10ps
`include "fp_noncomp_macros.svh"

module fp_noncomp_tb;
  import fp_noncomp_pkg::*;

  localparam int MAX_ITEMS      = 128;
  localparam int TIMEOUT_CYCLES = 200;

  // One line of the vector file
  typedef struct packed {
    logic [1:0]           op;
    logic [2:0]           rnd;
    logic                 op_mod;
    logic [`FP_WIDTH-1:0] operand_a;
    logic [`FP_WIDTH-1:0] operand_b;
    logic [`FP_WIDTH-1:0] result;
    logic [4:0]           status;
    logic                 ext_bit;
    logic [9:0]           class_mask;
    logic                 is_class;
  } vector_t;

  logic         clk;
  logic         rst_n;
  logic         flush;
  logic         in_valid;
  logic         in_ready;
  noncomp_req_t in_req;
  logic         out_valid;
  logic         out_ready;
  noncomp_rsp_t out_rsp;
  logic         busy;

  vector_t      vectors [MAX_ITEMS];
  int           num_items;
  int           mismatch_count;
  int           timeout_count;
  int           setup_error_count;
  // Set once either side gives up and then stops the other side too
  logic         aborted;
  logic [31:0]  lcg_state;
  // Items held inside the DUT, counted from the observed transfers
  int           in_flight;
  logic         monitor_on;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  fp_noncomp_top DUT (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_req_i    (in_req),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_rsp_o   (out_rsp),
    .busy_o      (busy)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  // LCG with the classic C library constants
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Lines starting with # are comments
  task automatic load_vectors();
    int          fd;
    string       line;
    logic [31:0] col [10];
    num_items = 0;
    fd = $fopen("verif/fp_noncomp_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file verif/fp_noncomp_vectors.txt");
      setup_error_count++;
    end else begin
      while (!$feof(fd) && num_items < MAX_ITEMS) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                      col[3], col[4], col[5], col[6], col[7], col[8], col[9]) == 10) begin
            vectors[num_items].op         = col[0][1:0];
            vectors[num_items].rnd        = col[1][2:0];
            vectors[num_items].op_mod     = col[2][0];
            vectors[num_items].operand_a  = col[3];
            vectors[num_items].operand_b  = col[4];
            vectors[num_items].result     = col[5];
            vectors[num_items].status     = col[6][4:0];
            vectors[num_items].ext_bit    = col[7][0];
            vectors[num_items].class_mask = col[8][9:0];
            vectors[num_items].is_class   = col[9][0];
            num_items++;
          end
        end
      end
      $fclose(fd);
    end
    if (num_items == 0) begin
      $display("No test items were read from the vector file");
      setup_error_count++;
    end
  endtask

  task automatic check_field(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s expected %h, actual %h", $time, what, expected, actual);
      mismatch_count++;
    end
  endtask

  // Class mask only carries meaning on a classify response
  task automatic check_response(input int index);
    vector_t v;
    v = vectors[index];
    check_field($sformatf("item %0d tag", index), index, out_rsp.tag);
    check_field($sformatf("item %0d result", index), v.result, out_rsp.result);
    check_field($sformatf("item %0d status", index), v.status, out_rsp.status);
    check_field($sformatf("item %0d extension_bit", index), v.ext_bit,
                out_rsp.extension_bit);
    check_field($sformatf("item %0d is_class", index), v.is_class, out_rsp.is_class);
    if (v.is_class) begin
      check_field($sformatf("item %0d class_mask", index), v.class_mask,
                  out_rsp.class_mask);
    end
  endtask

  // ------------------------------------------------------------
  // Occupancy monitor
  // ------------------------------------------------------------

  // Checked on the falling edge, then the transfers due at the next rising edge are counted
  always @(negedge clk) begin
    if (monitor_on) begin
      check_field($sformatf("busy_o with %0d items held", in_flight), in_flight != 0,
                  busy);
      // Input side stalls only with both registers full and no downstream ready
      check_field($sformatf("in_ready_o with %0d items held", in_flight),
                  (in_flight < 2) || out_ready, in_ready);
      if (in_valid && in_ready) begin
        in_flight++;
      end
      if (out_valid && out_ready) begin
        in_flight--;
      end
    end
  end

  // ------------------------------------------------------------
  // Request driver and response receiver
  // ------------------------------------------------------------

  // Ready is looked at on the falling edge and the transfer follows on the next rising edge
  task automatic drive_items();
    noncomp_req_t req;
    int           waited;
    for (int i = 0; i < num_items && !aborted; i++) begin
      req.operand_a = vectors[i].operand_a;
      req.operand_b = vectors[i].operand_b;
      req.op        = op_e'(vectors[i].op);
      req.rnd       = rnd_e'(vectors[i].rnd);
      req.op_mod    = vectors[i].op_mod;
      req.tag       = `FP_TAG_WIDTH'(i);
      in_valid <= 1'b1;
      in_req   <= req;
      waited = 0;
      @(negedge clk);
      while (!in_ready && waited < TIMEOUT_CYCLES) begin
        @(negedge clk);
        waited++;
      end
      if (!in_ready) begin
        $display("Timed out waiting for in_ready_o to accept item %0d", i);
        timeout_count++;
        aborted = 1'b1;
      end
      @(posedge clk);
    end
    in_valid <= 1'b0;
  endtask

  // Random back-pressure with ready high in about 70 percent of cycles
  task automatic receive_items();
    int expected_tag;
    int idle;
    expected_tag = 0;
    idle         = 0;
    while (expected_tag < num_items && !aborted) begin
      out_ready <= ((next_random() >> 16) % 100) < 70;
      @(negedge clk);
      if (out_valid && out_ready) begin
        check_response(expected_tag);
        expected_tag++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT_CYCLES) begin
          $display("Timed out waiting for the response with tag %0d", expected_tag);
          timeout_count++;
          aborted = 1'b1;
        end
      end
      @(posedge clk);
    end
    // Held low so a duplicate item would keep busy_o high
    out_ready <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int waited;
    flush             = 1'b0;
    in_valid          = 1'b0;
    in_req            = '0;
    out_ready         = 1'b0;
    mismatch_count    = 0;
    timeout_count     = 0;
    setup_error_count = 0;
    aborted           = 1'b0;
    in_flight         = 0;
    monitor_on        = 1'b0;
    lcg_state         = 32'd3;
    load_vectors();

    waited = 0;
    while (rst_n !== 1'b1 && waited < TIMEOUT_CYCLES) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timed out waiting for reset to be released");
      timeout_count++;
    end

    // Idle state right after reset
    @(negedge clk);
    check_field("out_valid_o after reset", 1'b0, out_valid);
    check_field("busy_o after reset", 1'b0, busy);
    check_field("in_ready_o after reset", 1'b1, in_ready);

    @(posedge clk);
    monitor_on = 1'b1;
    fork
      drive_items();
      receive_items();
    join
    monitor_on = 1'b0;

    // Pipeline drains once the last response is gone
    waited = 0;
    @(negedge clk);
    while (busy && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (busy) begin
      $display("Timed out waiting for busy_o to fall after the last response");
      timeout_count++;
    end

    $display("Items: %0d, mismatches: %0d, timeouts: %0d, setup errors: %0d",
             num_items, mismatch_count, timeout_count, setup_error_count);
    if (mismatch_count + timeout_count + setup_error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== verif/fp_noncomp_vectors.txt ====
# Columns (hex): op rnd op_mod operand_a operand_b result status ext_bit class_mask is_class
# op 0 SGNJ, 1 MINMAX, 2 CMP, 3 CLASSIFY; class_mask is checked only where is_class is 1
# Sign injection
0 0 0 3F800000 C0000000 BF800000 00 1 000 0
0 0 1 3F800000 40000000 3F800000 00 0 000 0
0 1 0 3F800000 40000000 BF800000 00 1 000 0
0 1 1 C0000000 BF800000 40000000 00 0 000 0
0 2 1 C0000000 BF800000 40000000 00 0 000 0
0 2 1 C0000000 3F800000 C0000000 00 1 000 0
0 3 0 BF800000 40000000 BF800000 00 1 000 0
0 3 1 7FC00000 80000000 7FC00000 00 0 000 0
# Minimum and maximum
1 0 0 3F800000 40000000 3F800000 00 1 000 0
1 1 0 3F800000 40000000 40000000 00 1 000 0
1 0 0 BF800000 C0000000 C0000000 00 1 000 0
1 1 0 BF800000 C0000000 BF800000 00 1 000 0
1 0 0 00000000 80000000 80000000 00 1 000 0
1 1 0 00000000 80000000 00000000 00 1 000 0
1 0 0 3F800000 C0000000 C0000000 00 1 000 0
1 0 0 7FC00000 40000000 40000000 00 1 000 0
1 1 0 BF800000 FFC00000 BF800000 00 1 000 0
1 0 0 7FC00000 FFC00000 7FC00000 00 1 000 0
1 1 0 7F800001 3F800000 3F800000 10 1 000 0
1 0 0 7F800001 7FC00000 7FC00000 10 1 000 0
# Comparisons
2 0 0 3F800000 40000000 00000001 00 0 000 0
2 0 1 3F800000 40000000 00000000 00 0 000 0
2 0 0 40000000 40000000 00000001 00 0 000 0
2 1 0 40000000 40000000 00000000 00 0 000 0
2 1 0 C0000000 BF800000 00000001 00 0 000 0
2 1 1 3F800000 C0000000 00000001 00 0 000 0
2 2 0 00000000 80000000 00000001 00 0 000 0
2 2 1 3F800000 40000000 00000001 00 0 000 0
2 2 0 7FC00000 7FC00000 00000000 00 0 000 0
2 2 1 7FC00000 3F800000 00000001 00 0 000 0
2 0 0 7FC00000 3F800000 00000000 10 0 000 0
2 1 1 3F800000 FFC00000 00000000 10 0 000 0
2 2 0 7F800001 7F800001 00000000 10 0 000 0
2 2 1 3F800000 7F800001 00000001 10 0 000 0
2 0 1 7F800001 3F800000 00000000 10 0 000 0
# Classification
3 0 0 FF800000 00000000 00000000 00 0 001 1
3 0 0 BF800000 00000000 00000000 00 0 002 1
3 0 0 80000001 00000000 00000000 00 0 004 1
3 0 0 80000000 00000000 00000000 00 0 008 1
3 0 0 00000000 00000000 00000000 00 0 010 1
3 0 0 00000001 00000000 00000000 00 0 020 1
3 0 0 3F800000 00000000 00000000 00 0 040 1
3 0 0 7F800000 00000000 00000000 00 0 080 1
3 0 0 7F800001 00000000 00000000 00 0 100 1
3 0 0 7FC00000 00000000 00000000 00 0 200 1

// ==== verilog.f ====
+incdir+hw
hw/fp_noncomp_pkg.sv
hw/fp_classifier.sv
hw/fp_noncomp_ops.sv
hw/fp_pipe_stage.sv
hw/fp_noncomp_top.sv
verif/tb_clk_gen.sv
verif/fp_noncomp_tb.sv

// ==== Bender.yml ====
package:
  name: fp_noncomp

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fp_noncomp_pkg.sv
      - hw/fp_classifier.sv
      - hw/fp_noncomp_ops.sv
      - hw/fp_pipe_stage.sv
      - hw/fp_noncomp_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_clk_gen.sv
      - verif/fp_noncomp_tb.sv
